// ==== gray_converter.f ====
design/gray_conv_pkg.sv
design/conv_ctrl.sv
design/slice_engine.sv
design/word_store.sv
design/gray_converter_top.sv
verification/gray_converter_sva.sv
verification/gray_converter_tb.sv

// ==== verification/gray_converter_tb.sv ====
`timescale 1ns/1ps

module gray_converter_tb;
    import gray_conv_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 20;
    localparam int NUM_TRIPS    = 4;
    localparam int NUM_STALL    = 6;
    localparam int TOTAL_CONV   = 2 * (NUM_RANDOM + 4) + 2 * NUM_TRIPS + NUM_STALL + 2;
    // twice the nominal run plus one word length of slack per stalled word
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + TOTAL_CONV * (NUM_ROUNDS + 2)
                                       + NUM_STALL * NUM_ROUNDS);

    logic              clk;
    logic              rst;
    logic              enable;
    logic              converter_start;
    conv_mode_e        mode;
    logic [WORD_W-1:0] data_in;
    logic [WORD_W-1:0] data_out;
    logic              data_out_valid;

    logic [31:0]       lfsr = 32'h3d9cdd0c;
    logic [WORD_W-1:0] exp_q[$];
    string             name_q[$];
    int                start_q[$];
    logic [WORD_W-1:0] exp_word;
    string             exp_name;
    int                latency;
    logic [WORD_W-1:0] last_result;
    int                en_count    = 0; // enabled clock edges so far
    int                cycle_count = 0;

    gray_converter_top UUT (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .converter_start(converter_start),
        .mode           (mode),
        .data_in        (data_in),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

    always #50 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic random_bit();
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        return lfsr[0];
    endfunction

    function automatic logic [WORD_W-1:0] random_word();
        logic [WORD_W-1:0] w;
        for (int i = 0; i < WORD_W; i++) begin
            w[i] = random_bit();
        end
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [WORD_W-1:0] w,
                                                        input conv_mode_e m);
        logic [WORD_W-1:0] r;
        if (m == MODE_BIN_TO_GRAY) begin
            r = w ^ (w >> 1);
        end else begin
            for (int i = 0; i < WORD_W; i++) begin
                r[i] = ^(w >> i); // xor of this bit and everything above
            end
        end
        return r;
    endfunction

    // one accepted start and a wait for its valid
    // disturb pokes start, mode and data while the word is busy
    task automatic convert_word(input logic [WORD_W-1:0] w, input conv_mode_e m,
                                input string name, input bit stall, input bit disturb);
        int k;
        k = 1;
        @(posedge clk);
        #1;
        data_in         = w;
        mode            = m;
        enable          = 1'b1;
        converter_start = 1'b1;
        @(negedge clk);
        exp_q.push_back(expected_word(w, m));
        name_q.push_back(name);
        start_q.push_back(en_count);
        @(posedge clk);
        #1;
        converter_start = 1'b0;
        while (exp_q.size() != 0) begin
            enable = stall ? (random_bit() | random_bit()) : 1'b1;
            if (disturb && k == 4) begin
                converter_start = 1'b1;
                mode            = (m == MODE_BIN_TO_GRAY) ? MODE_GRAY_TO_BIN : MODE_BIN_TO_GRAY;
                data_in         = ~w;
            end
            if (disturb && k == 6) begin
                converter_start = 1'b0;
            end
            k++;
            @(posedge clk);
            #1;
        end
        enable = 1'b1;
    endtask

    task automatic run_direction(input conv_mode_e m, input string tag);
        logic [WORD_W-1:0] one;
        one = {{(WORD_W-1){1'b0}}, 1'b1};
        convert_word('0, m, {tag, "_zero"}, 1'b0, 1'b0);
        convert_word('1, m, {tag, "_ones"}, 1'b0, 1'b0);
        convert_word(one, m, {tag, "_bit0"}, 1'b0, 1'b0);
        convert_word(one << (WORD_W - 1), m, {tag, "_bit127"}, 1'b0, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            convert_word(random_word(), m, $sformatf("%s_rand_%0d", tag, i), 1'b0, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        if (enable) begin
            en_count++;
        end
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            report_error("timeout: conversions did not finish within the cycle limit");
        end
    end

    // compare at mid-cycle when the outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            assert (UUT.u_sva.error_count == 0)
                else report_error("a bound assertion on the DUT ports failed");
            if (data_out_valid) begin
                assert (exp_q.size() != 0)
                    else report_error("data_out_valid raised with no conversion pending");
                exp_word = exp_q.pop_front();
                exp_name = name_q.pop_front();
                latency  = en_count - start_q.pop_front();
                assert (data_out == exp_word)
                    else report_error($sformatf("mismatch %s expected %h actual %h",
                                                exp_name, exp_word, data_out));
                assert (latency == NUM_ROUNDS - 1)
                    else report_error($sformatf("mismatch %s latency expected %0d actual %0d",
                                                exp_name, NUM_ROUNDS - 1, latency));
                last_result = data_out;
            end else if (enable) begin
                assert (data_out == '0)
                    else report_error($sformatf("mismatch idle_output expected %h actual %h",
                                                {WORD_W{1'b0}}, data_out));
            end
        end
    end

    initial begin : main
        logic [WORD_W-1:0] w;
        clk             = 1'b0;
        rst             = 1'b1;
        enable          = 1'b1;
        converter_start = 1'b0;
        mode            = MODE_BIN_TO_GRAY;
        data_in         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) @(posedge clk); // idle gap with no valid expected

        run_direction(MODE_BIN_TO_GRAY, "b2g");
        run_direction(MODE_GRAY_TO_BIN, "g2b");

        for (int i = 0; i < NUM_TRIPS; i++) begin
            w = random_word();
            convert_word(w, MODE_BIN_TO_GRAY, $sformatf("trip_fwd_%0d", i), 1'b0, 1'b0);
            convert_word(last_result, MODE_GRAY_TO_BIN, $sformatf("trip_back_%0d", i),
                         1'b0, 1'b0);
            assert (last_result == w)
                else report_error($sformatf("mismatch trip_%0d expected %h actual %h",
                                            i, w, last_result));
        end

        for (int i = 0; i < NUM_STALL; i++) begin
            convert_word(random_word(), conv_mode_e'(i[0]), $sformatf("stall_%0d", i),
                         1'b1, 1'b0);
        end

        convert_word(random_word(), MODE_BIN_TO_GRAY, "busy_b2g", 1'b0, 1'b1);
        convert_word(random_word(), MODE_GRAY_TO_BIN, "busy_g2b", 1'b0, 1'b1);

        repeat (4) @(posedge clk);
        if (UUT.u_sva.error_count == 0 && exp_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_error("bound assertions failed or a start got no valid");
        end
    end

endmodule

// ==== verification/gray_converter_sva.sv ====
`timescale 1ns/1ps

module gray_converter_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             enable,
    input logic                             converter_start,
    input logic [gray_conv_pkg::WORD_W-1:0] data_out,
    input logic                             data_out_valid
);

    int unsigned error_count = 0; // failed assertions so far
    logic        start_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_seen <= 1'b0;
        end else if (converter_start) begin
            start_seen <= 1'b1;
        end
    end

    // one valid per word
    valid_single: assert property (@(posedge clk) disable iff (rst)
        data_out_valid |=> !data_out_valid)
        else begin
            error_count++;
            $error("data_out_valid high in two consecutive enabled cycles");
        end

    // a stalled last round may show the word without valid
    out_zero: assert property (@(posedge clk) disable iff (rst)
        (enable && !data_out_valid) |-> (data_out == '0))
        else begin
            error_count++;
            $error("data_out not zero in an enabled cycle without valid");
        end

    no_early_valid: assert property (@(posedge clk) disable iff (rst)
        !start_seen |-> !data_out_valid)
        else begin
            error_count++;
            $error("data_out_valid raised before any start");
        end

endmodule

bind gray_converter_top gray_converter_sva u_sva (.*);

// ==== design/gray_converter_top.sv ====
`timescale 1ns/1ps

module gray_converter_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  logic                             converter_start,
    input  gray_conv_pkg::conv_mode_e        mode,
    input  logic [gray_conv_pkg::WORD_W-1:0] data_in,
    output logic [gray_conv_pkg::WORD_W-1:0] data_out,
    output logic                             data_out_valid
);
    import gray_conv_pkg::*;

    conv_mode_e         dir;
    logic [ROUND_W-1:0] slice_idx;
    logic               first;
    logic               step;
    logic               last;
    logic [WORD_W-1:0]  src_word;
    logic [SLICE_W-1:0] slice_out;

    conv_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .converter_start(converter_start),
        .mode           (mode),
        .dir            (dir),
        .slice_idx      (slice_idx),
        .first          (first),
        .step           (step),
        .last           (last),
        .data_out_valid (data_out_valid)
    );

    slice_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .step     (step),
        .last     (last),
        .dir      (dir),
        .slice_idx(slice_idx),
        .src_word (src_word),
        .slice_out(slice_out)
    );

    word_store u_store (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .first    (first),
        .step     (step),
        .last     (last),
        .slice_idx(slice_idx),
        .data_in  (data_in),
        .slice_out(slice_out),
        .src_word (src_word),
        .data_out (data_out)
    );

endmodule

// ==== design/word_store.sv ====
`timescale 1ns/1ps

module word_store (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic                              first,
    input  logic                              step,
    input  logic                              last,
    input  logic [gray_conv_pkg::ROUND_W-1:0] slice_idx,
    input  logic [gray_conv_pkg::WORD_W-1:0]  data_in,
    input  logic [gray_conv_pkg::SLICE_W-1:0] slice_out,
    output logic [gray_conv_pkg::WORD_W-1:0]  src_word,
    output logic [gray_conv_pkg::WORD_W-1:0]  data_out
);
    import gray_conv_pkg::*;

    logic [WORD_W-1:0] word_q;
    logic [WORD_W-1:0] next_word;

    assign src_word = first ? data_in : word_q; // round 0 reads the input directly

    // untouched slices pass through, the converted one is patched in
    always_comb begin
        next_word = src_word;
        next_word[slice_idx*SLICE_W +: SLICE_W] = slice_out;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_q <= '0;
        end else if (enable) begin
            if (last) begin
                word_q <= '0;
            end else if (step) begin
                word_q <= next_word;
            end
        end
    end

    assign data_out = last ? next_word : '0;

endmodule

// ==== design/slice_engine.sv ====
`timescale 1ns/1ps

module slice_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic                              step,
    input  logic                              last,
    input  gray_conv_pkg::conv_mode_e         dir,
    input  logic [gray_conv_pkg::ROUND_W-1:0] slice_idx,
    input  logic [gray_conv_pkg::WORD_W-1:0]  src_word,
    output logic [gray_conv_pkg::SLICE_W-1:0] slice_out
);
    import gray_conv_pkg::*;

    logic [WORD_W:0]    ext_word;
    logic [SLICE_W:0]   window;     // selected slice plus the bit above it
    logic [SLICE_W-1:0] b2g_slice;
    logic [SLICE_W-1:0] g2b_slice;
    logic               carry_q;

    // a zero above the msb makes the top gray bit a plain copy
    assign ext_word = {1'b0, src_word};
    assign window   = ext_word[slice_idx*SLICE_W +: SLICE_W+1];

    // g(n) = b(n) ^ b(n+1)
    assign b2g_slice = window[SLICE_W-1:0] ^ window[SLICE_W:1];

    // b(n) = g(n) ^ b(n+1), seeded with the last bit of the slice above
    always_comb begin
        g2b_slice[SLICE_W-1] = window[SLICE_W-1] ^ carry_q;
        for (int i = SLICE_W - 2; i >= 0; i--) begin
            g2b_slice[i] = window[i] ^ g2b_slice[i + 1];
        end
    end

    assign slice_out = (dir == MODE_GRAY_TO_BIN) ? g2b_slice : b2g_slice;

    // carry is zero again before round 0 of the next word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry_q <= 1'b0;
        end else if (enable) begin
            if (last) begin
                carry_q <= 1'b0;
            end else if (step) begin
                carry_q <= slice_out[0];
            end
        end
    end

endmodule

// ==== design/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic                              converter_start,
    input  gray_conv_pkg::conv_mode_e         mode,
    output gray_conv_pkg::conv_mode_e         dir,
    output logic [gray_conv_pkg::ROUND_W-1:0] slice_idx,
    output logic                              first,
    output logic                              step,
    output logic                              last,
    output logic                              data_out_valid
);
    import gray_conv_pkg::*;

    localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(NUM_ROUNDS - 1);

    conv_state_e        state_q;
    conv_state_e        state_d;
    logic [ROUND_W-1:0] round_q;
    logic               busy;
    logic               accept;

    assign busy   = (state_q != ST_IDLE);
    assign accept = (state_q == ST_IDLE) && converter_start;

    // while idle the live mode drives round 0, it is held in the state from then on
    always_comb begin
        case (state_q)
            ST_BIN_TO_GRAY: dir = MODE_BIN_TO_GRAY;
            ST_GRAY_TO_BIN: dir = MODE_GRAY_TO_BIN;
            default:        dir = mode;
        endcase
    end

    // binary to gray walks up from slice 0, gray to binary walks down from the top
    assign slice_idx = (dir == MODE_BIN_TO_GRAY) ? round_q : LAST_ROUND - round_q;

    assign first = accept;
    assign step  = accept || busy;
    assign last  = busy && (round_q == LAST_ROUND);

    assign data_out_valid = last && enable; // one enabled cycle only

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (converter_start) begin
                    if (mode == MODE_GRAY_TO_BIN) begin
                        state_d = ST_GRAY_TO_BIN;
                    end else begin
                        state_d = ST_BIN_TO_GRAY;
                    end
                end
            end
            default: begin
                if (last) begin
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            round_q <= '0;
        end else if (enable) begin
            state_q <= state_d;
            if (step) begin
                round_q <= last ? '0 : round_q + 1'b1; // back to 0 for the next word
            end
        end
    end

endmodule

// ==== design/gray_conv_pkg.sv ====
package gray_conv_pkg;

    // datapath geometry
    localparam int WORD_W     = 128;
    localparam int SLICE_W    = 8;
    localparam int NUM_ROUNDS = WORD_W / SLICE_W;     // 16 rounds per word
    localparam int ROUND_W    = $clog2(NUM_ROUNDS);   // round counter and slice index

    // conversion direction, sampled on an accepted start
    typedef enum logic {
        MODE_BIN_TO_GRAY = 1'b0,
        MODE_GRAY_TO_BIN = 1'b1
    } conv_mode_e;

    // controller states, one converting state per direction
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_BIN_TO_GRAY = 2'd1,
        ST_GRAY_TO_BIN = 2'd2
    } conv_state_e;

endpackage
